//--- Bender.yml
package:
  name: digital_core

sources:
  - files:
      - hw/const_pack.sv
      - hw/debug_regs.sv
      - hw/adc_unfolding.sv
      - hw/data_slicer.sv
      - hw/prbs_checker.sv
      - hw/digital_core.sv
  - target: test
    files:
      - test/tb_digital_core.sv

//--- hw/adc_unfolding.sv
`timescale 1ns/1ps
`default_nettype none

module adc_unfolding (
    input  wire logic                                         clk_adc_i,
    input  wire logic                                         rst_n_i,
    input  wire const_pack::adc_word_t                        adc_i,
    input  wire const_pack::dbg_cfg_t                         cfg_i,
    output logic [const_pack::Nti-1:0][const_pack::Ncode-1:0] codes_o
);
    import const_pack::*;

    adc_word_t                 adc_q;
    logic signed [Ncode:0]     offset_ext;
    logic [Nti-1:0][Ncode-1:0] code_sat;

    // input capture stage
    always_ff @(posedge clk_adc_i) begin
        adc_q <= adc_i;
    end

    // one guard bit so the subtraction cannot wrap
    assign offset_ext = {cfg_i.offset[Ncode-1], cfg_i.offset};

    always_comb begin
        logic signed [Ncode:0] folded;
        logic signed [Ncode:0] diff;
        folded = '0;
        diff   = '0;
        for (int j = 0; j < Nti; j++) begin
            folded = $signed({{(Ncode + 1 - Nadc){1'b0}}, adc_q.mag[j]});
            // sign low means a negative sample
            if (!adc_q.sign[j]) begin
                folded = -folded;
            end
            diff = folded - offset_ext;
            if (diff > CODE_MAX) begin
                code_sat[j] = Ncode'(CODE_MAX);
            end else if (diff < CODE_MIN) begin
                code_sat[j] = Ncode'(CODE_MIN);
            end else begin
                code_sat[j] = diff[Ncode-1:0];
            end
        end
    end

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            codes_o <= '0;
        end else begin
            codes_o <= code_sat;
        end
    end

endmodule

`default_nettype wire

//--- hw/const_pack.sv
package const_pack;

    // datapath sizes
    localparam int Nti   = 16;
    localparam int Nadc  = 8;
    localparam int Ncode = Nadc + 1;
    localparam int Nprbs = 7;
    localparam int Ncnt  = 32;

    // host port data width
    localparam int Nreg = 16;

    // signed range of an unfolded code
    localparam int CODE_MAX = (1 << (Ncode - 1)) - 1;
    localparam int CODE_MIN = -(1 << (Ncode - 1));

    // bit positions in REG_CTRL
    localparam int CTRL_CLR_BIT = 0;
    localparam int CTRL_EN_BIT  = 1;
    localparam int CTRL_INV_BIT = 2;

    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_THRESH = 3'd1,
        REG_OFFSET = 3'd2,
        REG_TOTAL  = 3'd3,
        REG_ERRORS = 3'd4
    } reg_addr_e;

    typedef enum logic [1:0] {
        CHK_IDLE = 2'd0,
        CHK_SEED = 2'd1,
        CHK_RUN  = 2'd2
    } chk_state_e;

    // sign 1 means a positive sample
    typedef struct packed {
        logic [Nti-1:0][Nadc-1:0] mag;
        logic [Nti-1:0]           sign;
    } adc_word_t;

    typedef struct packed {
        reg_addr_e       addr;
        logic            write;
        logic [Nreg-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic signed [Ncode-1:0] offset;
        logic signed [Ncode-1:0] thresh;
        logic                    invert;
        logic                    chk_en;
        logic                    soft_clr;
    } dbg_cfg_t;

    typedef struct packed {
        logic [Ncnt-1:0] total_bits;
        logic [Ncnt-1:0] err_bits;
        logic            locked;
    } dbg_stat_t;

endpackage

//--- hw/data_slicer.sv
`timescale 1ns/1ps
`default_nettype none

module data_slicer (
    input  wire logic                                         clk_adc_i,
    input  wire logic                                         rst_n_i,
    input  wire logic [const_pack::Nti-1:0][const_pack::Ncode-1:0] codes_i,
    input  wire const_pack::dbg_cfg_t                         cfg_i,
    output logic [const_pack::Nti-1:0]                        bits_o
);
    import const_pack::*;

    logic [Nti-1:0] decision;

    // a code equal to the threshold counts as a one
    always_comb begin
        for (int j = 0; j < Nti; j++) begin
            decision[j] = ($signed(codes_i[j]) >= $signed(cfg_i.thresh)) ^ cfg_i.invert;
        end
    end

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= decision;
        end
    end

endmodule

`default_nettype wire

//--- hw/debug_regs.sv
`timescale 1ns/1ps
`default_nettype none

module debug_regs (
    input  wire logic                   clk_adc_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   req_valid_i,
    input  wire const_pack::reg_req_t   req_i,
    output logic                        ack_o,
    output logic [const_pack::Nreg-1:0] rdata_o,
    output const_pack::dbg_cfg_t        cfg_o,
    input  wire const_pack::dbg_stat_t  stat_i
);
    import const_pack::*;

    typedef enum logic {
        RSP_IDLE = 1'b0,
        RSP_ACK  = 1'b1
    } rsp_state_e;

    rsp_state_e              state_q;
    logic signed [Ncode-1:0] offset_q;
    logic signed [Ncode-1:0] thresh_q;
    logic                    invert_q;
    logic                    chk_en_q;
    logic                    soft_clr_q;
    logic [Nreg-1:0]         rdata_q;
    logic [Nreg-1:0]         rd_value;
    logic                    accept;

    // one access per handshake, taken on the first edge that sees req
    assign accept = (state_q == RSP_IDLE) && req_valid_i;

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RSP_IDLE;
        end else begin
            case (state_q)
                RSP_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= RSP_ACK;
                    end
                end
                RSP_ACK: begin
                    // hold ack until the host releases req
                    if (!req_valid_i) begin
                        state_q <= RSP_IDLE;
                    end
                end
                default: begin
                    state_q <= RSP_IDLE;
                end
            endcase
        end
    end

    // read mux, counters show only their low half
    always_comb begin
        rd_value = '0;
        case (req_i.addr)
            REG_CTRL: begin
                rd_value[CTRL_EN_BIT]  = chk_en_q;
                rd_value[CTRL_INV_BIT] = invert_q;
            end
            REG_THRESH: rd_value = {{(Nreg - Ncode){1'b0}}, thresh_q};
            REG_OFFSET: rd_value = {{(Nreg - Ncode){1'b0}}, offset_q};
            REG_TOTAL:  rd_value = stat_i.total_bits[Nreg-1:0];
            REG_ERRORS: rd_value = stat_i.err_bits[Nreg-1:0];
            default:    rd_value = '0;
        endcase
    end

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            offset_q   <= '0;
            thresh_q   <= '0;
            invert_q   <= 1'b0;
            chk_en_q   <= 1'b0;
            soft_clr_q <= 1'b0;
            rdata_q    <= '0;
        end else begin
            soft_clr_q <= 1'b0;
            if (accept && !req_i.write) begin
                rdata_q <= rd_value;
            end
            if (accept && req_i.write) begin
                case (req_i.addr)
                    REG_CTRL: begin
                        // clear bit is a strobe, not a stored field
                        soft_clr_q <= req_i.wdata[CTRL_CLR_BIT];
                        chk_en_q   <= req_i.wdata[CTRL_EN_BIT];
                        invert_q   <= req_i.wdata[CTRL_INV_BIT];
                    end
                    REG_THRESH: thresh_q <= req_i.wdata[Ncode-1:0];
                    REG_OFFSET: offset_q <= req_i.wdata[Ncode-1:0];
                    default: begin
                    end
                endcase
            end
        end
    end

    assign ack_o   = (state_q == RSP_ACK);
    assign rdata_o = rdata_q;

    assign cfg_o.offset   = offset_q;
    assign cfg_o.thresh   = thresh_q;
    assign cfg_o.invert   = invert_q;
    assign cfg_o.chk_en   = chk_en_q;
    assign cfg_o.soft_clr = soft_clr_q;

    // each ack answers a req seen on the previous edge
    assert property (@(posedge clk_adc_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_valid_i))
        else $error("ack raised without a pending request");

    assert property (@(posedge clk_adc_i) disable iff (!rst_n_i)
        cfg_o.soft_clr |=> !cfg_o.soft_clr)
        else $error("soft clear held longer than one cycle");

endmodule

`default_nettype wire

//--- hw/digital_core.sv
`timescale 1ns/1ps
`default_nettype none

module digital_core (
    input  wire logic                         clk_adc_i,
    input  wire logic                         rst_n_i,
    input  wire const_pack::adc_word_t        adc_i,
    input  wire logic                         reg_req_valid_i,
    input  wire const_pack::reg_req_t         reg_req_i,
    output wire logic                         reg_ack_o,
    output wire logic [const_pack::Nreg-1:0]  reg_rdata_o,
    output wire logic [const_pack::Nti-1:0]   bits_o
);
    import const_pack::*;

    dbg_cfg_t                  dbg_cfg;
    dbg_stat_t                 dbg_stat;
    logic [Nti-1:0][Ncode-1:0] codes;

    // host access and configuration
    debug_regs i_debug_regs (
        .clk_adc_i   (clk_adc_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (reg_req_valid_i),
        .req_i       (reg_req_i),
        .ack_o       (reg_ack_o),
        .rdata_o     (reg_rdata_o),
        .cfg_o       (dbg_cfg),
        .stat_i      (dbg_stat)
    );

    // sign-magnitude to signed code
    adc_unfolding i_adc_unfolding (
        .clk_adc_i (clk_adc_i),
        .rst_n_i   (rst_n_i),
        .adc_i     (adc_i),
        .cfg_i     (dbg_cfg),
        .codes_o   (codes)
    );

    data_slicer i_data_slicer (
        .clk_adc_i (clk_adc_i),
        .rst_n_i   (rst_n_i),
        .codes_i   (codes),
        .cfg_i     (dbg_cfg),
        .bits_o    (bits_o)
    );

    // sliced bits are checked and also leave the core
    prbs_checker i_prbs_checker (
        .clk_adc_i (clk_adc_i),
        .rst_n_i   (rst_n_i),
        .bits_i    (bits_o),
        .cfg_i     (dbg_cfg),
        .stat_o    (dbg_stat)
    );

endmodule

`default_nettype wire

//--- hw/prbs_checker.sv
`timescale 1ns/1ps
`default_nettype none

module prbs_checker (
    input  wire logic                      clk_adc_i,
    input  wire logic                      rst_n_i,
    input  wire logic [const_pack::Nti-1:0] bits_i,
    input  wire const_pack::dbg_cfg_t       cfg_i,
    output const_pack::dbg_stat_t          stat_o
);
    import const_pack::*;

    chk_state_e               state_q;
    logic [Nprbs-1:0]         hist_q;
    logic [Nti+Nprbs-1:0]     stream;
    logic [Nti-1:0]           mismatch;
    logic [$clog2(Nti+1)-1:0] err_cnt;
    logic [Ncnt:0]            total_sum;
    logic [Ncnt:0]            err_sum;
    logic [Ncnt-1:0]          total_q;
    logic [Ncnt-1:0]          err_q;

    // history sits below the word, oldest bit at index 0
    assign stream = {bits_i, hist_q};

    // x^7+x^6+1, bit n predicted from received bits n-7 and n-6
    always_comb begin
        err_cnt = '0;
        for (int j = 0; j < Nti; j++) begin
            mismatch[j] = bits_i[j] ^ stream[j] ^ stream[j+1];
            err_cnt     = err_cnt + mismatch[j];
        end
    end

    assign total_sum = {1'b0, total_q} + (Ncnt + 1)'(Nti);
    assign err_sum   = {1'b0, err_q} + (Ncnt + 1)'(err_cnt);

    // received history always follows the line, so SEED only skips counting
    always_ff @(posedge clk_adc_i) begin
        hist_q <= bits_i[Nti-1 -: Nprbs];
    end

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= CHK_IDLE;
            total_q <= '0;
            err_q   <= '0;
        end else if (cfg_i.soft_clr) begin
            state_q <= cfg_i.chk_en ? CHK_SEED : CHK_IDLE;
            total_q <= '0;
            err_q   <= '0;
        end else begin
            case (state_q)
                CHK_IDLE: begin
                    if (cfg_i.chk_en) begin
                        state_q <= CHK_SEED;
                    end
                end
                CHK_SEED: begin
                    state_q <= cfg_i.chk_en ? CHK_RUN : CHK_IDLE;
                end
                CHK_RUN: begin
                    if (!cfg_i.chk_en) begin
                        state_q <= CHK_IDLE;
                    end
                    // saturate at all ones
                    total_q <= total_sum[Ncnt] ? '1 : total_sum[Ncnt-1:0];
                    err_q   <= err_sum[Ncnt] ? '1 : err_sum[Ncnt-1:0];
                end
                default: begin
                    state_q <= CHK_IDLE;
                end
            endcase
        end
    end

    assign stat_o.total_bits = total_q;
    assign stat_o.err_bits   = err_q;
    assign stat_o.locked     = (state_q == CHK_RUN);

    assert property (@(posedge clk_adc_i) disable iff (!rst_n_i)
        err_q <= total_q)
        else $error("error count above total bit count");

    // only a running checker or a soft clear may move the counters
    assert property (@(posedge clk_adc_i) disable iff (!rst_n_i)
        (state_q != CHK_RUN && !cfg_i.soft_clr) |=> ($stable(total_q) && $stable(err_q)))
        else $error("counters changed outside CHK_RUN");

endmodule

`default_nettype wire

//--- test/tb_digital_core.sv
`timescale 1ns/1ps

module tb_digital_core;
    import const_pack::*;

    localparam int CLK_PERIOD  = 100;
    localparam int SLICE_SETS  = 8;
    localparam int SLICE_WORDS = 24;
    localparam int STIM_CYCLES = SLICE_SETS * (SLICE_WORDS + 16) + 300;

    logic            clk_adc_i;
    logic            rst_n_i;
    adc_word_t       adc_i;
    logic            reg_req_valid_i;
    reg_req_t        reg_req_i;
    logic            reg_ack_o;
    logic [Nreg-1:0] reg_rdata_o;
    logic [Nti-1:0]  bits_o;

    int                      errors = 0;
    int                      checks = 0;
    int                      fill = 0;
    logic                    prbs_mode = 1'b0;
    logic                    full_scale = 1'b0;
    logic                    record = 1'b0;
    logic                    slice_chk = 1'b0;
    logic [Nti-1:0]          flip_req = '0;
    logic signed [Ncode-1:0] cur_offset = '0;
    logic signed [Ncode-1:0] cur_thresh = '0;
    logic                    cur_invert = 1'b0;
    adc_word_t               hist [3];
    logic                    line_bits [$];
    time                     clr_time = 0;

    digital_core i_digital_core (
        .clk_adc_i       (clk_adc_i),
        .rst_n_i         (rst_n_i),
        .adc_i           (adc_i),
        .reg_req_valid_i (reg_req_valid_i),
        .reg_req_i       (reg_req_i),
        .reg_ack_o       (reg_ack_o),
        .reg_rdata_o     (reg_rdata_o),
        .bits_o          (bits_o)
    );

    initial begin
        clk_adc_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_adc_i = ~clk_adc_i;
    end

    // x^7+x^6+1, s[0] is the bit seven places back
    function automatic logic [Nprbs+Nti-1:0] ref_prbs(input logic [Nprbs-1:0] st);
        logic [Nti-1:0]   word;
        logic [Nprbs-1:0] s;
        s = st;
        for (int j = 0; j < Nti; j++) begin
            word[j] = s[0] ^ s[1];
            s = {word[j], s[Nprbs-1:1]};
        end
        return {s, word};
    endfunction

    function automatic logic [Nti-1:0] ref_bits(input adc_word_t w, input int offset,
                                                input int thresh, input logic inv);
        logic [Nti-1:0] b;
        int             code;
        for (int j = 0; j < Nti; j++) begin
            code = w.sign[j] ? int'(w.mag[j]) : -int'(w.mag[j]);
            code = code - offset;
            if (code > CODE_MAX) begin
                code = CODE_MAX;
            end else if (code < CODE_MIN) begin
                code = CODE_MIN;
            end
            b[j] = (code >= thresh) ^ inv;
        end
        return b;
    endfunction

    // mispredictions over the recorded line, first seven bits only seed history
    function automatic int ref_err_count();
        int n;
        n = 0;
        for (int i = Nprbs; i < line_bits.size(); i++) begin
            if (line_bits[i] != (line_bits[i-7] ^ line_bits[i-6])) begin
                n++;
            end
        end
        return n;
    endfunction

    // one seed word after the clear edge, then Nti bits per word
    function automatic logic [Nreg-1:0] ref_total(input time t_read);
        longint words;
        words = (t_read - clr_time) / CLK_PERIOD - 3;
        return (words > 0) ? Nreg'(words * Nti) : '0;
    endfunction

    task automatic check_bits(input logic [Nti-1:0] got, input logic [Nti-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: bits_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_reg(input logic [Nreg-1:0] got, input logic [Nreg-1:0] exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_stat(input dbg_stat_t got, input dbg_stat_t exp);
        checks++;
        if (got.total_bits !== exp.total_bits || got.err_bits !== exp.err_bits) begin
            errors++;
            $display("Error at %0d ns: total %0d errors %0d, expected total %0d errors %0d",
                     $time, got.total_bits, got.err_bits, exp.total_bits, exp.err_bits);
        end
    endtask

    task automatic step_to_mid_cycle();
        @(posedge clk_adc_i);
        #20;
    endtask

    // four-phase access, t_acc is the edge that raised ack
    task automatic host_access(input reg_addr_e addr, input logic wr,
                               input logic [Nreg-1:0] wdata,
                               output logic [Nreg-1:0] rdata, output time t_acc);
        @(posedge clk_adc_i);
        #1;
        reg_req_i.addr  = addr;
        reg_req_i.write = wr;
        reg_req_i.wdata = wdata;
        reg_req_valid_i = 1'b1;
        do begin
            @(posedge clk_adc_i);
            #1;
        end while (!reg_ack_o);
        rdata = reg_rdata_o;
        t_acc = $time - 1;
        reg_req_valid_i = 1'b0;
        do begin
            @(posedge clk_adc_i);
            #1;
        end while (reg_ack_o);
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [Nreg-1:0] wdata,
                             output time t_acc);
        logic [Nreg-1:0] unused;
        host_access(addr, 1'b1, wdata, unused, t_acc);
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [Nreg-1:0] rdata,
                            output time t_acc);
        host_access(addr, 1'b0, '0, rdata, t_acc);
    endtask

    task automatic write_readback(input reg_addr_e addr, input logic [Nreg-1:0] wdata,
                                  input logic [Nreg-1:0] exp);
        logic [Nreg-1:0] rd;
        time             t;
        reg_write(addr, wdata, t);
        reg_read(addr, rd, t);
        check_reg(rd, exp, addr.name());
    endtask

    task automatic read_stat(output dbg_stat_t st, output time t_tot);
        logic [Nreg-1:0] d;
        time             t;
        st = '0;
        reg_read(REG_TOTAL, d, t_tot);
        st.total_bits = Ncnt'(d);
        reg_read(REG_ERRORS, d, t);
        st.err_bits = Ncnt'(d);
    endtask

    task automatic expect_stat(input int err_exp, input logic running);
        dbg_stat_t got;
        dbg_stat_t exp;
        time       t;
        read_stat(got, t);
        exp = '0;
        exp.total_bits = running ? Ncnt'(ref_total(t)) : '0;
        exp.err_bits = Ncnt'(err_exp);
        check_stat(got, exp);
    endtask

    task automatic set_slicer(input int offset, input int thresh, input logic inv,
                              input logic full);
        time t;
        step_to_mid_cycle();
        slice_chk = 1'b0;
        full_scale = full;
        cur_offset = Ncode'(offset);
        cur_thresh = Ncode'(thresh);
        cur_invert = inv;
        reg_write(REG_OFFSET, {{(Nreg - Ncode){1'b0}}, cur_offset}, t);
        reg_write(REG_THRESH, {{(Nreg - Ncode){1'b0}}, cur_thresh}, t);
        reg_write(REG_CTRL, Nreg'(inv) << CTRL_INV_BIT, t);
        step_to_mid_cycle();
        slice_chk = 1'b1;
    endtask

    // one word per cycle, sign bits carry PRBS7 in prbs mode
    task automatic drive_adc();
        adc_word_t            w;
        logic [Nprbs+Nti-1:0] nxt;
        logic [Nprbs-1:0]     st;
        st = '1;
        forever begin
            @(posedge clk_adc_i);
            #1;
            nxt = ref_prbs(st);
            st = nxt[Nti +: Nprbs];
            for (int j = 0; j < Nti; j++) begin
                w.mag[j] = full_scale ? '1 : Nadc'($urandom);
                if (prbs_mode) begin
                    // zero would slice as one whatever the sign
                    w.mag[j] = Nadc'(1 + $urandom % 255);
                end
            end
            w.sign = prbs_mode ? (nxt[Nti-1:0] ^ flip_req) : Nti'($urandom);
            flip_req = '0;
            adc_i = w;
            if (record) begin
                for (int j = 0; j < Nti; j++) begin
                    line_bits.push_back(w.sign[j]);
                end
            end
        end
    endtask

    // words as the DUT samples them, newest first
    always @(posedge clk_adc_i) begin
        if (!slice_chk) begin
            fill = 0;
        end else begin
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = adc_i;
            if (fill < 3) begin
                fill++;
            end
        end
    end

    always @(negedge clk_adc_i) begin
        if (slice_chk && fill >= 3) begin
            check_bits(bits_o, ref_bits(hist[2], cur_offset, cur_thresh, cur_invert));
        end
    end

    initial begin
        logic [Nreg-1:0] rd;
        logic [Nti-1:0]  flips [4];
        time             t;
        void'($urandom(82));
        flips = '{16'h0008, 16'h1004, 16'h0060, 16'h8000};
        rst_n_i = 1'b0;
        adc_i = '0;
        reg_req_valid_i = 1'b0;
        reg_req_i = '0;
        fork
            drive_adc();
        join_none
        repeat (3) @(posedge clk_adc_i);
        #1;
        rst_n_i = 1'b1;
        check_bits(bits_o, '0);

        for (int a = 0; a < 5; a++) begin
            reg_read(reg_addr_e'(a), rd, t);
            check_reg(rd, '0, "register after reset");
        end
        write_readback(REG_THRESH, 16'h0155, 16'h0155);
        write_readback(REG_OFFSET, 16'h00a3, 16'h00a3);
        write_readback(REG_CTRL, 16'h0006, 16'h0006);
        write_readback(REG_CTRL, 16'h0000, 16'h0000);

        // first two sets drive the saturation corners
        set_slicer(-200, 255, 1'b0, 1'b1);
        repeat (SLICE_WORDS) @(posedge clk_adc_i);
        set_slicer(200, -255, 1'b1, 1'b1);
        repeat (SLICE_WORDS) @(posedge clk_adc_i);
        for (int s = 2; s < SLICE_SETS; s++) begin
            set_slicer(int'($urandom % 512) - 256, int'($urandom % 129) - 64,
                       1'($urandom), 1'b0);
            repeat (SLICE_WORDS) @(posedge clk_adc_i);
        end

        // clean PRBS with the slicer at zero
        set_slicer(0, 0, 1'b0, 1'b0);
        step_to_mid_cycle();
        prbs_mode = 1'b1;
        repeat (4) @(posedge clk_adc_i);
        reg_write(REG_CTRL, 16'h0003, clr_time);
        repeat (20) @(posedge clk_adc_i);
        expect_stat(0, 1'b1);
        repeat (37) @(posedge clk_adc_i);
        expect_stat(0, 1'b1);

        // flipped signs in known words
        step_to_mid_cycle();
        line_bits.delete();
        record = 1'b1;
        for (int i = 0; i < 4; i++) begin
            repeat (5) @(posedge clk_adc_i);
            step_to_mid_cycle();
            flip_req = flips[i];
        end
        repeat (5) @(posedge clk_adc_i);
        step_to_mid_cycle();
        record = 1'b0;
        repeat (4) @(posedge clk_adc_i);
        expect_stat(ref_err_count(), 1'b1);

        // clear with the checker off, then restart it
        reg_write(REG_CTRL, 16'h0001, t);
        expect_stat(0, 1'b0);
        reg_write(REG_CTRL, 16'h0003, clr_time);
        expect_stat(0, 1'b1);
        repeat (30) @(posedge clk_adc_i);
        expect_stat(0, 1'b1);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #((STIM_CYCLES * 2 + 1000) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the watchdog limit");
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- verilog.f
hw/const_pack.sv
hw/debug_regs.sv
hw/adc_unfolding.sv
hw/data_slicer.sv
hw/prbs_checker.sv
hw/digital_core.sv
test/tb_digital_core.sv
